// ==== src/wb_cfg_pkg.sv ====
package wb_cfg_pkg;

  // ##############################
  // bus geometry
  // ##############################

  localparam int num_masters = 3;
  // wide enough for any master index
  localparam int mid_w = 2;

  localparam int adr_w = 32;
  localparam int dat_w = 16;
  localparam int sel_w = 2;

  // ##############################
  // slave sizes
  // ##############################

  // word address bits 8:1 select the word
  localparam int ram_words = 256;

  // arbiter FSM
  typedef enum logic {
    arb_idle = 1'b0,
    arb_busy = 1'b1
  } arb_state_e;

endpackage

// ==== src/wb_map_pkg.sv ====
package wb_map_pkg;

  // region field in the byte address
  localparam int region_hi = 31;
  localparam int region_lo = 28;

  // counter index inside region 1, word address bits
  localparam int stat_off_hi = 2;
  localparam int stat_off_lo = 1;

  // region_none is only a tag, the decoder never casts the field
  typedef enum logic [region_hi-region_lo:0] {
    region_ram  = 4'd0,
    region_stat = 4'd1,
    region_none = 4'd15
  } region_e;

endpackage

// ==== src/wb_bus_if.sv ====
`timescale 1ns/1ns

interface wb_bus_if;

  logic                             cyc;
  logic                             stb;
  logic                             we;
  logic [wb_cfg_pkg::sel_w-1:0]     sel;
  logic [wb_cfg_pkg::adr_w-1:0]     adr;
  logic [wb_cfg_pkg::dat_w-1:0]     dat_w;
  logic [wb_cfg_pkg::dat_w-1:0]     dat_r;
  logic                             ack;
  logic                             err;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

// ==== src/wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter (
  input  logic                                               wb_clk_i,
  input  logic                                               wb_rst_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                 wbm_cyc_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                 wbm_stb_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                 wbm_we_i,
  input  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::sel_w-1:0] wbm_sel_i,
  input  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::adr_w-1:0] wbm_adr_i,
  input  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::dat_w-1:0] wbm_dat_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                 wbm_mask_i,
  output logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::dat_w-1:0] wbm_dat_o,
  output logic [wb_cfg_pkg::num_masters-1:0]                 wbm_ack_o,
  output logic [wb_cfg_pkg::num_masters-1:0]                 wbm_err_o,
  wb_bus_if.master                                           bus_o,
  output logic                                               grant_stb_o,
  output logic [wb_cfg_pkg::mid_w-1:0]                       grant_id_o
);

  logic [wb_cfg_pkg::num_masters-1:0] pending_q;
  logic [wb_cfg_pkg::mid_w-1:0]       active_q;
  logic                               cyc_q;
  wb_cfg_pkg::arb_state_e             state_q;

  // last pending master wins
  function automatic logic [wb_cfg_pkg::mid_w-1:0] pick_master(
    input logic [wb_cfg_pkg::num_masters-1:0] req
  );
    logic [wb_cfg_pkg::mid_w-1:0] id;
    id = '0;
    for (int i = 0; i < wb_cfg_pkg::num_masters; i++) begin
      if (req[i]) begin
        id = wb_cfg_pkg::mid_w'(i);
      end
    end
    return id;
  endfunction

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending_q <= '0;
      active_q  <= '0;
      cyc_q     <= 1'b0;
      state_q   <= wb_cfg_pkg::arb_idle;
    end else begin
      cyc_q     <= 1'b0;
      pending_q <= pending_q | (wbm_cyc_i & wbm_stb_i & wbm_mask_i);
      // the response clears the granted bit even if its request is still held
      if (bus_o.ack || bus_o.err) begin
        pending_q[active_q] <= 1'b0;
        state_q             <= wb_cfg_pkg::arb_idle;
      end
      if (state_q == wb_cfg_pkg::arb_idle && |pending_q) begin
        cyc_q    <= 1'b1;
        state_q  <= wb_cfg_pkg::arb_busy;
        active_q <= pick_master(pending_q);
      end
    end
  end

  // ##############################
  // shared bus side
  // ##############################

  assign bus_o.cyc   = cyc_q;
  assign bus_o.stb   = cyc_q;
  assign bus_o.we    = wbm_we_i[active_q];
  assign bus_o.sel   = wbm_sel_i[active_q*wb_cfg_pkg::sel_w +: wb_cfg_pkg::sel_w];
  assign bus_o.adr   = wbm_adr_i[active_q*wb_cfg_pkg::adr_w +: wb_cfg_pkg::adr_w];
  assign bus_o.dat_w = wbm_dat_i[active_q*wb_cfg_pkg::dat_w +: wb_cfg_pkg::dat_w];

  assign grant_stb_o = cyc_q;
  assign grant_id_o  = active_q;

  // responses go back to the granted master only
  for (genvar i = 0; i < wb_cfg_pkg::num_masters; i++) begin : g_resp
    logic own;
    assign own = (active_q == wb_cfg_pkg::mid_w'(i));
    assign wbm_ack_o[i] = own & bus_o.ack;
    assign wbm_err_o[i] = own & bus_o.err;
    assign wbm_dat_o[i*wb_cfg_pkg::dat_w +: wb_cfg_pkg::dat_w] = own ? bus_o.dat_r : '0;
  end

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(bus_o.ack && bus_o.err)
  );

  // busy from the grant through the response cycle
  a_cyc_from_idle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(cyc_q) |-> !$past(cyc_q, 2)
  );

endmodule

// ==== src/wb_addr_decode.sv ====
`timescale 1ns/1ns

module wb_addr_decode (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  wb_bus_if.slave   up_i,
  wb_bus_if.master  ram_o,
  wb_bus_if.master  stat_o
);

  wb_map_pkg::region_e region;
  logic                hit;
  logic                none_err_q;

  always_comb begin
    region = wb_map_pkg::region_none;
    if (up_i.adr[wb_map_pkg::region_hi:wb_map_pkg::region_lo] == wb_map_pkg::region_ram) begin
      region = wb_map_pkg::region_ram;
    end else if (up_i.adr[wb_map_pkg::region_hi:wb_map_pkg::region_lo] ==
                 wb_map_pkg::region_stat) begin
      region = wb_map_pkg::region_stat;
    end
  end

  assign hit = up_i.cyc & up_i.stb;

  // strobe only to the addressed slave
  assign ram_o.cyc   = up_i.cyc & (region == wb_map_pkg::region_ram);
  assign ram_o.stb   = up_i.stb & (region == wb_map_pkg::region_ram);
  assign ram_o.we    = up_i.we;
  assign ram_o.sel   = up_i.sel;
  assign ram_o.adr   = up_i.adr;
  assign ram_o.dat_w = up_i.dat_w;

  assign stat_o.cyc   = up_i.cyc & (region == wb_map_pkg::region_stat);
  assign stat_o.stb   = up_i.stb & (region == wb_map_pkg::region_stat);
  assign stat_o.we    = up_i.we;
  assign stat_o.sel   = up_i.sel;
  assign stat_o.adr   = up_i.adr;
  assign stat_o.dat_w = up_i.dat_w;

  // unmapped region
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      none_err_q <= 1'b0;
    end else begin
      none_err_q <= hit && (region == wb_map_pkg::region_none);
    end
  end

  assign up_i.ack   = ram_o.ack | stat_o.ack;
  assign up_i.err   = ram_o.err | stat_o.err | none_err_q;
  assign up_i.dat_r = ram_o.ack ? ram_o.dat_r : stat_o.dat_r;

  a_no_ack_unmapped: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (hit && region == wb_map_pkg::region_none) |=> !up_i.ack
  );

endmodule

// ==== src/wb_ram.sv ====
`timescale 1ns/1ns

module wb_ram (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  wb_bus_if.slave  bus_i
);

  logic [wb_cfg_pkg::dat_w-1:0]             mem [wb_cfg_pkg::ram_words];
  logic [$clog2(wb_cfg_pkg::ram_words)-1:0] idx;
  logic [wb_cfg_pkg::dat_w-1:0]             dat_q;
  logic                                     ack_q;
  logic                                     hit;

  // word address, byte bit dropped
  assign idx = bus_i.adr[$clog2(wb_cfg_pkg::ram_words):1];
  assign hit = bus_i.cyc & bus_i.stb;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  // storage and read data
  always_ff @(posedge wb_clk_i) begin
    if (hit) begin
      dat_q <= mem[idx];
      if (bus_i.we) begin
        for (int b = 0; b < wb_cfg_pkg::sel_w; b++) begin
          if (bus_i.sel[b]) begin
            mem[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
          end
        end
      end
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.err   = 1'b0;
  assign bus_i.dat_r = dat_q;

  a_write_has_sel: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) (hit && bus_i.we) |-> (bus_i.sel != '0)
  );

endmodule

// ==== src/wb_stat_regs.sv ====
`timescale 1ns/1ns

module wb_stat_regs (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  wb_bus_if.slave                       bus_i,
  input  logic                          grant_stb_i,
  input  logic [wb_cfg_pkg::mid_w-1:0]  grant_id_i
);

  logic [wb_cfg_pkg::dat_w-1:0] cnt_q [wb_cfg_pkg::num_masters];
  logic [wb_map_pkg::stat_off_hi-wb_map_pkg::stat_off_lo:0] idx;
  logic [wb_cfg_pkg::dat_w-1:0] dat_q;
  logic                         ack_q;
  logic                         err_q;
  logic                         hit;
  logic                         valid;

  assign idx   = bus_i.adr[wb_map_pkg::stat_off_hi:wb_map_pkg::stat_off_lo];
  assign hit   = bus_i.cyc & bus_i.stb;
  assign valid = (int'(idx) < wb_cfg_pkg::num_masters);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      for (int k = 0; k < wb_cfg_pkg::num_masters; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      ack_q <= hit && valid;
      err_q <= hit && !valid;
      // a clear wins over this edge's grant
      for (int k = 0; k < wb_cfg_pkg::num_masters; k++) begin
        if (hit && valid && bus_i.we && int'(idx) == k) begin
          cnt_q[k] <= '0;
        end else if (grant_stb_i && int'(grant_id_i) == k) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  // value before this edge's increment
  always_ff @(posedge wb_clk_i) begin
    if (hit && valid) begin
      dat_q <= cnt_q[idx];
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.err   = err_q;
  assign bus_i.dat_r = dat_q;

  a_only_stat_region: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    hit |-> bus_i.adr[wb_map_pkg::region_hi:wb_map_pkg::region_lo] == wb_map_pkg::region_stat
  );

endmodule

// ==== src/wb_shared_bus.sv ====
`timescale 1ns/1ns

module wb_shared_bus (
  input  logic                                                 wb_clk_i,
  input  logic                                                 wb_rst_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_cyc_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_stb_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_we_i,
  input  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::sel_w-1:0] wbm_sel_i,
  input  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::adr_w-1:0] wbm_adr_i,
  input  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::dat_w-1:0] wbm_dat_i,
  input  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_mask_i,
  output logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::dat_w-1:0] wbm_dat_o,
  output logic [wb_cfg_pkg::num_masters-1:0]                   wbm_ack_o,
  output logic [wb_cfg_pkg::num_masters-1:0]                   wbm_err_o
);

  logic                         grant_stb;
  logic [wb_cfg_pkg::mid_w-1:0] grant_id;

  wb_bus_if arb_bus ();
  wb_bus_if ram_bus ();
  wb_bus_if stat_bus ();

  // ##############################
  // arbitration
  // ##############################

  wb_arbiter wb_arbiter_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wbm_cyc_i   (wbm_cyc_i),
    .wbm_stb_i   (wbm_stb_i),
    .wbm_we_i    (wbm_we_i),
    .wbm_sel_i   (wbm_sel_i),
    .wbm_adr_i   (wbm_adr_i),
    .wbm_dat_i   (wbm_dat_i),
    .wbm_mask_i  (wbm_mask_i),
    .wbm_dat_o   (wbm_dat_o),
    .wbm_ack_o   (wbm_ack_o),
    .wbm_err_o   (wbm_err_o),
    .bus_o       (arb_bus.master),
    .grant_stb_o (grant_stb),
    .grant_id_o  (grant_id)
  );

  // ##############################
  // decode and slaves
  // ##############################

  wb_addr_decode wb_addr_decode_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .up_i     (arb_bus.slave),
    .ram_o    (ram_bus.master),
    .stat_o   (stat_bus.master)
  );

  wb_ram wb_ram_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (ram_bus.slave)
  );

  wb_stat_regs wb_stat_regs_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .bus_i       (stat_bus.slave),
    .grant_stb_i (grant_stb),
    .grant_id_i  (grant_id)
  );

endmodule

// ==== test/tb_wb_shared_bus.sv ====
`timescale 1ns/1ns

module tb_wb_shared_bus;

  typedef struct {
    logic        with_prev;
    int          master;
    logic        we;
    logic [1:0]  sel;
    logic [31:0] adr;
    logic [15:0] wdat;
    logic        exp_err;
    int          hold;
    logic [15:0] exp_rd;
  } row_t;

  logic                                                 wb_clk_i;
  logic                                                 wb_rst_i;
  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_cyc_i;
  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_stb_i;
  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_we_i;
  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::sel_w-1:0] wbm_sel_i;
  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::adr_w-1:0] wbm_adr_i;
  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::dat_w-1:0] wbm_dat_i;
  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_mask_i;
  logic [wb_cfg_pkg::num_masters*wb_cfg_pkg::dat_w-1:0] wbm_dat_o;
  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_ack_o;
  logic [wb_cfg_pkg::num_masters-1:0]                   wbm_err_o;

  row_t        rows [64];
  int          n_rows = 0;
  logic [15:0] ram_model [256];
  logic [15:0] cnt_model [3];
  int          seed = 32'h98112495;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 1000;

  wb_shared_bus wb_shared_bus_i (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: a master got no response within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  task automatic add_row(input logic prev, input int m, input logic we, input logic [1:0] sel,
                         input logic [31:0] adr, input logic exp_err, input int hold);
    int rnd;
    rnd = $random(seed);
    rows[n_rows] = '{prev, m, we, sel, adr, rnd[15:0], exp_err, hold, 16'h0000};
    n_rows++;
  endtask

  // reference model for one transfer
  task automatic model_step(input int r, output logic [15:0] rd);
    logic [7:0] widx;
    logic [1:0] cidx;
    widx = rows[r].adr[8:1];
    cidx = rows[r].adr[2:1];
    rd = '0;
    if (rows[r].adr[31:28] == 4'd0) begin
      if (!rows[r].we) begin
        rd = ram_model[widx];
      end
      if (rows[r].we && rows[r].sel[0]) begin
        ram_model[widx][7:0] = rows[r].wdat[7:0];
      end
      if (rows[r].we && rows[r].sel[1]) begin
        ram_model[widx][15:8] = rows[r].wdat[15:8];
      end
    end
    if (rows[r].adr[31:28] == 4'd1 && cidx != 2'd3 && !rows[r].we) begin
      rd = cnt_model[cidx];
    end
    cnt_model[rows[r].master] = cnt_model[rows[r].master] + 16'd1;
    // a clear wins over this grant
    if (rows[r].adr[31:28] == 4'd1 && cidx != 2'd3 && rows[r].we) begin
      cnt_model[cidx] = '0;
    end
  endtask

  // ##############################
  // one batch of rows started in the same cycle
  // ##############################

  task automatic run_batch(input int first, input int last);
    logic [2:0]  waiting;
    logic [2:0]  resp;
    logic [15:0] rd;
    int          row_of [3];
    int          hold [3];
    int          order [$];
    int          lat;
    int          r;
    int          m;
    bit          any_hold;
    waiting = '0;
    any_hold = 0;
    lat = 0;
    hold = '{0, 0, 0};
    // highest master completes first
    for (int k = 2; k >= 0; k--) begin
      for (int j = first; j <= last; j++) begin
        if (rows[j].master == k) begin
          model_step(j, rd);
          rows[j].exp_rd = rd;
        end
      end
    end
    for (int j = first; j <= last; j++) begin
      m = rows[j].master;
      row_of[m] = j;
      hold[m] = rows[j].hold;
      any_hold = any_hold || (rows[j].hold > 0);
      waiting[m] = 1'b1;
      wbm_cyc_i[m] = 1'b1;
      wbm_stb_i[m] = 1'b1;
      wbm_we_i[m] = rows[j].we;
      wbm_sel_i[m*wb_cfg_pkg::sel_w +: wb_cfg_pkg::sel_w] = rows[j].sel;
      wbm_adr_i[m*wb_cfg_pkg::adr_w +: wb_cfg_pkg::adr_w] = rows[j].adr;
      wbm_dat_i[m*wb_cfg_pkg::dat_w +: wb_cfg_pkg::dat_w] = rows[j].wdat;
      wbm_mask_i[m] = (rows[j].hold == 0);
    end
    while (waiting != 3'b000) begin
      @(posedge wb_clk_i);
      #1;
      lat++;
      resp = wbm_ack_o | wbm_err_o;
      check($onehot0(resp), $sformatf("at %0t more than one master answered", $time));
      for (int k = 0; k < 3; k++) begin
        if (resp[k]) begin
          r = row_of[k];
          check(waiting[k], $sformatf("at %0t master %0d answered without a request", $time, k));
          check(wbm_mask_i[k], $sformatf("at %0t master %0d answered while masked", $time, k));
          check(wbm_err_o[k] == rows[r].exp_err,
                $sformatf("error at %0t: wbm_err_o[%0d] is %b, expected %b",
                          $time, k, wbm_err_o[k], rows[r].exp_err));
          check(wbm_ack_o[k] == !rows[r].exp_err,
                $sformatf("error at %0t: wbm_ack_o[%0d] is %b, expected %b",
                          $time, k, wbm_ack_o[k], !rows[r].exp_err));
          if (!rows[r].we && !rows[r].exp_err) begin
            rd = wbm_dat_o[k*wb_cfg_pkg::dat_w +: wb_cfg_pkg::dat_w];
            check(rd === rows[r].exp_rd,
                  $sformatf("error at %0t: wbm_dat_o[%0d] is %h, expected %h",
                            $time, k, rd, rows[r].exp_rd));
          end
          if (first == last && !any_hold) begin
            check(lat == 3, $sformatf("at %0t lone request answered after %0d edges, not 3",
                                      $time, lat));
          end
          order.push_back(k);
          waiting[k] = 1'b0;
          wbm_cyc_i[k] = 1'b0;
          wbm_stb_i[k] = 1'b0;
        end
      end
      for (int k = 0; k < 3; k++) begin
        if (waiting[k] && hold[k] > 0) begin
          hold[k]--;
          wbm_mask_i[k] = (hold[k] == 0);
        end
      end
    end
    if (!any_hold) begin
      for (int i = 0; i + 1 < order.size(); i++) begin
        check(order[i] > order[i+1], $sformatf("master %0d completed before master %0d",
                                               order[i], order[i+1]));
      end
    end
    @(posedge wb_clk_i);
    #1;
    check((wbm_ack_o | wbm_err_o) == '0, $sformatf("at %0t response with no request", $time));
  endtask

  task automatic build_table();
    // full words from each master
    add_row(1'b0, 0, 1'b1, 2'b11, 32'h0000_0010, 1'b0, 0);
    add_row(1'b0, 1, 1'b1, 2'b11, 32'h0000_0020, 1'b0, 0);
    add_row(1'b0, 2, 1'b1, 2'b11, 32'h0000_01fe, 1'b0, 0);
    add_row(1'b0, 1, 1'b0, 2'b11, 32'h0000_0010, 1'b0, 0);
    add_row(1'b0, 2, 1'b0, 2'b11, 32'h0000_0020, 1'b0, 0);
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h0000_01fe, 1'b0, 0);
    // byte lanes
    add_row(1'b0, 1, 1'b1, 2'b01, 32'h0000_0010, 1'b0, 0);
    add_row(1'b0, 2, 1'b0, 2'b11, 32'h0000_0010, 1'b0, 0);
    add_row(1'b0, 0, 1'b1, 2'b10, 32'h0000_0020, 1'b0, 0);
    add_row(1'b0, 1, 1'b0, 2'b11, 32'h0000_0020, 1'b0, 0);
    // unmapped regions and counter index 3
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h2000_0010, 1'b1, 0);
    add_row(1'b0, 2, 1'b1, 2'b11, 32'hf000_0010, 1'b1, 0);
    add_row(1'b0, 1, 1'b1, 2'b11, 32'h1000_0006, 1'b1, 0);
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h1000_0006, 1'b1, 0);
    add_row(1'b0, 2, 1'b0, 2'b11, 32'h0000_0010, 1'b0, 0);
    // contention
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h0000_0010, 1'b0, 0);
    add_row(1'b1, 1, 1'b0, 2'b11, 32'h0000_0020, 1'b0, 0);
    add_row(1'b1, 2, 1'b1, 2'b11, 32'h0000_01fe, 1'b0, 0);
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h0000_0040, 1'b0, 0);
    add_row(1'b1, 2, 1'b1, 2'b11, 32'h0000_0040, 1'b0, 0);
    // grant counters
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h1000_0000, 1'b0, 0);
    add_row(1'b0, 1, 1'b1, 2'b11, 32'h1000_0000, 1'b0, 0);
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h1000_0000, 1'b0, 0);
    add_row(1'b0, 2, 1'b1, 2'b11, 32'h1000_0004, 1'b0, 0);
    add_row(1'b0, 2, 1'b0, 2'b11, 32'h1000_0004, 1'b0, 0);
    add_row(1'b0, 1, 1'b0, 2'b11, 32'h1000_0002, 1'b0, 0);
    // masked master
    add_row(1'b0, 0, 1'b0, 2'b11, 32'h0000_0010, 1'b0, 6);
    add_row(1'b0, 1, 1'b0, 2'b11, 32'h1000_0000, 1'b0, 0);
  endtask

  initial begin
    int first;
    int last;
    int hold_sum;
    wb_rst_i = 1'b1;
    wbm_cyc_i = '0;
    wbm_stb_i = '0;
    wbm_we_i = '0;
    wbm_sel_i = '0;
    wbm_adr_i = '0;
    wbm_dat_i = '0;
    wbm_mask_i = '1;
    cnt_model = '{16'h0000, 16'h0000, 16'h0000};
    build_table();
    hold_sum = 0;
    for (int j = 0; j < n_rows; j++) begin
      hold_sum += rows[j].hold;
    end
    limit = 12 * n_rows + hold_sum + 8;
    repeat (4) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    first = 0;
    while (first < n_rows) begin
      last = first;
      while (last + 1 < n_rows && rows[last+1].with_prev) begin
        last++;
      end
      run_batch(first, last);
      first = last + 1;
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/wb_cfg_pkg.sv
src/wb_map_pkg.sv
src/wb_bus_if.sv
src/wb_arbiter.sv
src/wb_addr_decode.sv
src/wb_ram.sv
src/wb_stat_regs.sv
src/wb_shared_bus.sv
test/tb_wb_shared_bus.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_wb_shared_bus -f list.f &&
  out="$(./obj_dir/Vtb_wb_shared_bus)" &&
  printf '%s\n' "$out" &&
  printf '%s\n' "$out" | grep -qF '*** PASSED ***' &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
